// File: hdl/alu_defs.svh
// ALU shared constants
// Data and opcode widths, EFLAGS bit positions
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// Operand and result width
`define ALU_WIDTH 32

// Opcode field width
`define OP_WIDTH 4

// EFLAGS bit positions, other bits reserved as zero
`define FLAG_CF 0
`define FLAG_PF 2
`define FLAG_AF 4
`define FLAG_ZF 6
`define FLAG_SF 7
`define FLAG_DF 10
`define FLAG_OF 11

`endif

// File: hdl/alu_pkg.sv
// ALU package
// Data word, flags word and opcode types
`include "alu_defs.svh"

package alu_pkg;

	// --------------------------------------------------
	// Datapath words
	// --------------------------------------------------

	// Operand and result word
	typedef logic [`ALU_WIDTH-1:0] word_t;

	// Architectural EFLAGS, always 32 bits
	typedef logic [31:0] eflags_t;

	// --------------------------------------------------
	// Opcodes
	// --------------------------------------------------

	// Codes 0 to 9 are fixed, the cases file uses them
	typedef enum logic [`OP_WIDTH-1:0] {
		// Arithmetic class
		OP_ADD = 0,
		OP_ADC = 1,
		OP_SUB = 2,
		OP_SBB = 3,
		// Flags only, result kept
		OP_CMP = 4,
		// Logic class
		OP_AND = 5,
		OP_OR  = 6,
		OP_XOR = 7,
		// Direction flag control
		OP_CLD = 8,
		OP_STD = 9
	} alu_op_e;

endpackage

// File: hdl/alu_adder.sv
// ALU adder/subtractor
// Sum, carry or borrow, auxiliary carry and signed overflow
`include "alu_defs.svh"

module alu_adder (
	input  alu_pkg::alu_op_e op,
	input  alu_pkg::word_t   a,
	input  alu_pkg::word_t   b,
	input  logic             cf_in,
	output alu_pkg::word_t   sum,
	output logic             carry_out,
	output logic             aux_carry,
	output logic             overflow
);
	import alu_pkg::*;

	// Opcode decode
	logic is_sub;
	logic use_cf;

	// Effective operands
	word_t b_eff;
	logic  cin;

	// Adder with one extra bit for the carry
	logic [`ALU_WIDTH:0] sum_ext;
	logic                carry_raw;

	// --------------------------------------------------
	// Operand and carry-in selection
	// --------------------------------------------------

	// SUB, SBB and CMP go through the inverted path
	assign is_sub = (op == OP_SUB) || (op == OP_SBB) || (op == OP_CMP);

	// Only the with-carry forms look at the stored CF
	assign use_cf = (op == OP_ADC) || (op == OP_SBB);

	// Two's complement subtract: a + ~b + 1
	assign b_eff = is_sub ? ~b : b;

	always_comb begin
		// Plain add: 0, ADC: CF
		// Plain sub: 1, SBB: ~CF (borrow in)
		if (use_cf)
			cin = is_sub ? ~cf_in : cf_in;
		else
			cin = is_sub;
	end

	// --------------------------------------------------
	// Add
	// --------------------------------------------------

	assign sum_ext = {1'b0, a} + {1'b0, b_eff} + {{`ALU_WIDTH{1'b0}}, cin};

	assign sum       = sum_ext[`ALU_WIDTH-1:0];
	assign carry_raw = sum_ext[`ALU_WIDTH];

	// x86 CF on subtract means unsigned borrow, so invert
	assign carry_out = is_sub ? ~carry_raw : carry_raw;

	// Carry (or borrow) into bit 4
	// Same form for add and sub when the original b is used
	assign aux_carry = a[4] ^ b[4] ^ sum[4];

	// Operands of like sign, result sign differs
	assign overflow = (sum[`ALU_WIDTH-1] ^ a[`ALU_WIDTH-1])
		& ~(a[`ALU_WIDTH-1] ^ b_eff[`ALU_WIDTH-1]);

endmodule

// File: hdl/alu_logic.sv
// ALU logic unit
// Bitwise AND, OR and XOR of the two operands
module alu_logic (
	input  alu_pkg::alu_op_e op,
	input  alu_pkg::word_t   a,
	input  alu_pkg::word_t   b,
	output alu_pkg::word_t   logic_out
);
	import alu_pkg::*;

	// Individual bitwise results
	word_t and_res;
	word_t or_res;
	word_t xor_res;

	// --------------------------------------------------
	// Bitwise operations
	// --------------------------------------------------

	assign and_res = a & b;
	assign or_res  = a | b;
	assign xor_res = a ^ b;

	// --------------------------------------------------
	// Opcode select
	// --------------------------------------------------

	always_comb begin
		case (op)
			OP_AND: begin
				logic_out = and_res;
			end
			OP_OR: begin
				logic_out = or_res;
			end
			OP_XOR: begin
				logic_out = xor_res;
			end
			default: begin
				// Arithmetic and DF ops, not used by flags unit
				logic_out = '0;
			end
		endcase
	end

endmodule

// File: hdl/alu_flags.sv
// ALU flag unit
// Picks the result, builds SF/ZF/PF and class flag rules, holds result and EFLAGS
`include "alu_defs.svh"

module alu_flags (
	input  logic             clk,
	input  logic             rst,
	input  logic             op_valid,
	input  alu_pkg::alu_op_e op,
	input  alu_pkg::word_t   sum,
	input  logic             carry_out,
	input  logic             aux_carry,
	input  logic             overflow,
	input  alu_pkg::word_t   logic_out,
	output logic             result_valid,
	output alu_pkg::word_t   result,
	output alu_pkg::eflags_t eflags,
	output logic             cf_in
);
	import alu_pkg::*;

	// Opcode classes
	logic is_arith;
	logic is_logic;
	logic loads_result;

	// Selected result and derived flags
	word_t sel_result;
	logic  zf;
	logic  pf;
	logic  sf;

	// Next register values
	word_t   result_next;
	eflags_t eflags_next;

	// --------------------------------------------------
	// Decode
	// --------------------------------------------------

	always_comb begin
		is_arith = 1'b0;
		is_logic = 1'b0;
		case (op)
			OP_ADD, OP_ADC, OP_SUB, OP_SBB, OP_CMP: begin
				is_arith = 1'b1;
			end
			OP_AND, OP_OR, OP_XOR: begin
				is_logic = 1'b1;
			end
			default: begin
				// CLD, STD and unused codes
				is_arith = 1'b0;
			end
		endcase
	end

	// CMP is arithmetic but does not write back
	assign loads_result = (is_arith && (op != OP_CMP)) || is_logic;

	// --------------------------------------------------
	// Result flags
	// --------------------------------------------------

	assign sel_result = is_logic ? logic_out : sum;

	// All 32 bits zero
	assign zf = ~|sel_result;
	// Even number of ones in low byte
	assign pf = ~^sel_result[7:0];
	// Sign bit
	assign sf = sel_result[`ALU_WIDTH-1];

	// --------------------------------------------------
	// Next EFLAGS and result
	// --------------------------------------------------

	always_comb begin
		// Default: hold everything
		eflags_next = eflags;
		result_next = result;

		if (is_arith || is_logic) begin
			// Rebuilt from zero so reserved bits stay clear
			eflags_next = '0;
			eflags_next[`FLAG_SF] = sf;
			eflags_next[`FLAG_ZF] = zf;
			eflags_next[`FLAG_PF] = pf;
			// DF survives arithmetic and logic ops
			eflags_next[`FLAG_DF] = eflags[`FLAG_DF];
			// CF, OF, AF only from the adder, logic clears them
			if (is_arith) begin
				eflags_next[`FLAG_CF] = carry_out;
				eflags_next[`FLAG_OF] = overflow;
				eflags_next[`FLAG_AF] = aux_carry;
			end
		end else if (op == OP_STD) begin
			eflags_next[`FLAG_DF] = 1'b1;
		end else if (op == OP_CLD) begin
			eflags_next[`FLAG_DF] = 1'b0;
		end

		if (loads_result)
			result_next = sel_result;
	end

	// --------------------------------------------------
	// Registers
	// --------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			result_valid <= 1'b0;
			result       <= '0;
			eflags       <= '0;
		end else begin
			// One-cycle strobe follows op_valid
			result_valid <= op_valid;
			if (op_valid) begin
				result <= result_next;
				eflags <= eflags_next;
			end
		end
	end

	// Stored CF, pre-edge value for ADC/SBB chains
	assign cf_in = eflags[`FLAG_CF];

endmodule

// File: hdl/alu_top.sv
// ALU top level
// Adder and logic unit in parallel, feeding the flag unit
module alu_top (
	input  logic             clk,
	input  logic             rst,
	input  logic             op_valid,
	input  alu_pkg::alu_op_e op,
	input  alu_pkg::word_t   a,
	input  alu_pkg::word_t   b,
	output logic             result_valid,
	output alu_pkg::word_t   result,
	output alu_pkg::eflags_t eflags
);
	import alu_pkg::*;

	// --------------------------------------------------
	// Internal wires
	// --------------------------------------------------

	// Adder outputs
	word_t sum;
	logic  carry_out;
	logic  aux_carry;
	logic  overflow;

	// Logic unit output
	word_t logic_out;

	// Stored CF back to the adder
	logic cf_in;

	// --------------------------------------------------
	// Arithmetic path
	// --------------------------------------------------

	// Combinational, zero latency
	alu_adder adder_i (
		.op        (op),
		.a         (a),
		.b         (b),
		.cf_in     (cf_in),
		.sum       (sum),
		.carry_out (carry_out),
		.aux_carry (aux_carry),
		.overflow  (overflow)
	);

	// --------------------------------------------------
	// Logic path
	// --------------------------------------------------

	// Runs beside the adder on the same operands
	alu_logic logic_i (
		.op        (op),
		.a         (a),
		.b         (b),
		.logic_out (logic_out)
	);

	// --------------------------------------------------
	// Flags and output registers
	// --------------------------------------------------

	// One cycle from op_valid to result_valid
	alu_flags flags_i (
		.clk          (clk),
		.rst          (rst),
		.op_valid     (op_valid),
		.op           (op),
		.sum          (sum),
		.carry_out    (carry_out),
		.aux_carry    (aux_carry),
		.overflow     (overflow),
		.logic_out    (logic_out),
		.result_valid (result_valid),
		.result       (result),
		.eflags       (eflags),
		.cf_in        (cf_in)
	);

endmodule

// File: test/alu_tb.sv
// ALU testbench
// Replays the cases file through alu_top, checks result, EFLAGS and valid timing
`include "alu_defs.svh"

module alu_tb;
	import alu_pkg::*;

	// Clock period and reset length in cycles
	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 10;

	// DUT ports
	logic    clk;
	logic    rst;
	logic    op_valid;
	alu_op_e op;
	word_t   a;
	word_t   b;
	logic    result_valid;
	word_t   result;
	eflags_t eflags;

	// Cases, in file order
	logic [3:0] op_q[$];
	word_t      a_q[$];
	word_t      b_q[$];
	word_t      res_q[$];
	eflags_t    flags_q[$];
	int         gap_q[$];

	// Bookkeeping
	int   errors;
	int   n_pass;
	int   n_fail;
	int   n_cases;
	logic loaded;

	// --------------------------------------------------
	// DUT and clock
	// --------------------------------------------------

	alu_top alu_top_i (
		.clk          (clk),
		.rst          (rst),
		.op_valid     (op_valid),
		.op           (op),
		.a            (a),
		.b            (b),
		.result_valid (result_valid),
		.result       (result),
		.eflags       (eflags)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------

	// Mnemonic for the log
	function automatic string op_name(input logic [3:0] code);
		case (alu_op_e'(code))
			OP_ADD: return "ADD";
			OP_ADC: return "ADC";
			OP_SUB: return "SUB";
			OP_SBB: return "SBB";
			OP_CMP: return "CMP";
			OP_AND: return "AND";
			OP_OR:  return "OR";
			OP_XOR: return "XOR";
			OP_CLD: return "CLD";
			OP_STD: return "STD";
			default: return "???";
		endcase
	endfunction

	// Set flags by name, highest bit first
	function automatic string flag_list(input eflags_t f);
		string s;
		s = "";
		if (f[`FLAG_OF]) s = {s, " OF"};
		if (f[`FLAG_DF]) s = {s, " DF"};
		if (f[`FLAG_SF]) s = {s, " SF"};
		if (f[`FLAG_ZF]) s = {s, " ZF"};
		if (f[`FLAG_AF]) s = {s, " AF"};
		if (f[`FLAG_PF]) s = {s, " PF"};
		if (f[`FLAG_CF]) s = {s, " CF"};
		if (s == "")
			s = " none";
		return s;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic load_cases();
		int          fd;
		int          code;
		int          fields;
		string       line;
		logic [31:0] f_op, f_a, f_b;
		logic [31:0] f_res, f_flags, f_gap;
		fd = $fopen("test/alu_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open the cases file test/alu_cases.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				code = $fgets(line, fd);
				fields = $sscanf(line, "%h %h %h %h %h %h",
					f_op, f_a, f_b, f_res, f_flags, f_gap);
				// Comment and blank lines give no fields
				if (code > 0 && fields == 6) begin
					op_q.push_back(f_op[3:0]);
					a_q.push_back(f_a);
					b_q.push_back(f_b);
					res_q.push_back(f_res);
					flags_q.push_back(f_flags);
					gap_q.push_back(int'(f_gap));
				end else if (code > 0 && fields > 0) begin
					$display("Malformed line in the cases file: %s", line);
					errors++;
				end
			end
			$fclose(fd);
			if (op_q.size() == 0) begin
				$display("The cases file holds no cases");
				errors++;
			end
		end
		n_cases = op_q.size();
	endtask

	task automatic apply_case(input int i);
		op_valid = 1'b1;
		op       = alu_op_e'(op_q[i]);
		a        = a_q[i];
		b        = b_q[i];
	endtask

	task automatic go_idle();
		op_valid = 1'b0;
		op       = OP_ADD;
		a        = '0;
		b        = '0;
	endtask

	// Registers straight out of reset
	task automatic check_reset();
		int errors_before;
		errors_before = errors;
		check_value("result_valid", {31'b0, result_valid}, 32'h0);
		check_value("result", result, 32'h0);
		check_value("eflags", eflags, 32'h0);
		if (errors == errors_before) begin
			n_pass++;
			$display("reset state: ok");
		end else begin
			n_fail++;
			$display("reset state: FAILED");
		end
	endtask

	// One falling edge after the strobe
	task automatic check_case(input int i);
		int errors_before;
		errors_before = errors;
		if (result_valid !== 1'b1) begin
			$display("At %0t result_valid was not high one cycle after the strobe of case %0d",
				$time, i);
			errors++;
		end
		check_value("result", result, res_q[i]);
		check_value("eflags", eflags, flags_q[i]);
		if (errors == errors_before) begin
			n_pass++;
			$display("case %0d %s %h, %h: ok, flags%s", i, op_name(op_q[i]),
				a_q[i], b_q[i], flag_list(eflags));
		end else begin
			n_fail++;
			$display("case %0d %s %h, %h: FAILED", i, op_name(op_q[i]), a_q[i], b_q[i]);
		end
	endtask

	// No strobe in the previous cycle
	task automatic check_idle();
		if (result_valid !== 1'b0) begin
			$display("At %0t result_valid was high in a cycle that followed no strobe", $time);
			errors++;
		end
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------

	initial begin
		clk      = 1'b0;
		rst      = 1'b1;
		op_valid = 1'b0;
		op       = OP_ADD;
		a        = '0;
		b        = '0;
		errors   = 0;
		n_pass   = 0;
		n_fail   = 0;
		n_cases  = 0;
		loaded   = 1'b0;

		load_cases();
		loaded = 1'b1;

		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		check_reset();

		// Gap 0 means the next strobe follows in the very next cycle
		for (int i = 0; i < n_cases; i++) begin
			apply_case(i);
			@(negedge clk);
			check_case(i);
			go_idle();
			for (int g = 0; g < gap_q[i]; g++) begin
				@(negedge clk);
				check_idle();
			end
		end

		$display("%0d tests passed, %0d tests failed, %0d errors", n_pass, n_fail, errors);
		if (errors == 0 && n_fail == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// --------------------------------------------------
	// Watchdog
	// --------------------------------------------------

	// Budget of four cycles per case on top of reset
	initial begin
		wait (loaded === 1'b1);
		#((RESET_CYCLES + 4 * n_cases + 20) * CLK_PERIOD);
		$display("Timeout: the cases did not finish within the expected number of cycles");
		$display(">>> FAIL");
		$finish;
	end

endmodule

// File: list.f
+incdir+hdl
hdl/alu_pkg.sv
hdl/alu_adder.sv
hdl/alu_logic.sv
hdl/alu_flags.sv
hdl/alu_top.sv
test/alu_tb.sv

// File: test/alu_cases.txt
# opcode a b expected_result expected_eflags idle_cycles_after, all hex, one case per line
# opcodes 0 ADD, 1 ADC, 2 SUB, 3 SBB, 4 CMP, 5 AND, 6 OR, 7 XOR, 8 CLD, 9 STD
0 7FFFFFFF 00000001 80000000 00000894 0
0 FFFFFFFF 00000001 00000000 00000055 1
1 00000005 00000003 00000009 00000004 0
2 00000000 00000001 FFFFFFFF 00000095 0
3 00000010 00000001 0000000E 00000010 1
0 0000000F 00000001 00000010 00000010 1
0 FFFFFFFF FFFFFFFF FFFFFFFE 00000091 0
1 FFFFFFFF 00000000 00000000 00000055 0
1 00000001 00000001 00000003 00000004 1
0 80000008 80000008 00000010 00000811 0
5 F0F0F0F0 FF00FF00 F000F000 00000084 0
7 12345678 12345678 00000000 00000044 0
6 00000001 00000006 00000007 00000000 1
4 00000000 00000001 00000007 00000095 0
9 00000000 00000000 00000007 00000495 0
8 00000000 00000000 00000007 00000095 1
9 00000000 00000000 00000007 00000495 0
0 00000001 00000001 00000002 00000400 2
